// File: sm_pkg.sv
package sm_pkg;

  // ==================================================
  // widths
  // ==================================================
  localparam int data_w    = 32;          // cpu and packet word
  localparam int addr_w    = 8;           // cpu byte address
  localparam int reg_idx_w = addr_w - 2;  // word index, bits 1:0 dropped
  localparam int ram_aw    = 5;
  localparam int ram_depth = 1 << ram_aw; // 32 result words
  localparam int timer_w   = 32;
  localparam int leds_w    = 4;
  localparam int fft_w     = 5;           // log2 fft size field
  localparam int mode_w    = 8;
  localparam int seq_w     = 8;           // matches header seq byte
  localparam int cnt_w     = ram_aw + 1;  // holds 1..32 words

  // clamp bounds on fft_size, 2^(n-5) words per packet
  localparam int fft_log_min = 5;
  localparam int fft_log_max = 10;

  // reset values
  localparam logic [leds_w-1:0] leds_rst = 4'b1010;
  localparam logic [fft_w-1:0]  fft_rst  = fft_w'(fft_log_max);

  // ==================================================
  // id / version
  // ==================================================
  localparam logic [data_w-1:0] firmware_id = 32'h5553_5250; // "USRP"
  localparam logic [15:0]       fw_major    = 16'h000A;
  localparam logic [15:0]       fw_minor    = 16'h0001;
  localparam logic [data_w-1:0] bad_read    = 32'hABAD_BABE; // unmapped reads

  // ==================================================
  // register map, word index = byte address >> 2
  // ==================================================
  localparam logic [reg_idx_w-1:0] reg_id        = 6'd0;  // ro
  localparam logic [reg_idx_w-1:0] reg_version   = 6'd1;  // ro
  localparam logic [reg_idx_w-1:0] reg_status    = 6'd2;  // busy, seq, write error
  localparam logic [reg_idx_w-1:0] reg_leds      = 6'd3;
  localparam logic [reg_idx_w-1:0] reg_fft_size  = 6'd4;
  localparam logic [reg_idx_w-1:0] reg_mode      = 6'd5;
  localparam logic [reg_idx_w-1:0] reg_res_addr  = 6'd6;  // result write pointer
  localparam logic [reg_idx_w-1:0] reg_res_data  = 6'd7;  // wo, auto increment
  localparam logic [reg_idx_w-1:0] reg_send      = 6'd8;  // wo command
  localparam logic [reg_idx_w-1:0] reg_tmr_start = 6'd9;  // wo command
  localparam logic [reg_idx_w-1:0] reg_tmr_stop  = 6'd10; // wo command
  localparam logic [reg_idx_w-1:0] reg_timer0    = 6'd11; // send -> header
  localparam logic [reg_idx_w-1:0] reg_timer1    = 6'd12; // send -> done
  localparam logic [reg_idx_w-1:0] reg_timer2    = 6'd13; // user timer

  // framer fsm encoding
  localparam logic [2:0] st_idle   = 3'd0;
  localparam logic [2:0] st_fetch  = 3'd1;
  localparam logic [2:0] st_header = 3'd2;
  localparam logic [2:0] st_data   = 3'd3;
  localparam logic [2:0] st_done   = 3'd4;

  // packet word, raw or as header fields
  typedef struct packed {
    logic [7:0] seq;   // packet sequence number
    logic [7:0] total; // packets in this transfer
    logic [7:0] spare;
    logic [7:0] mode;  // low byte
  } pkt_hdr_t;

  typedef union packed {
    logic [data_w-1:0] raw;
    pkt_hdr_t          hdr;
  } pkt_word_u;

endpackage

// File: reg_decode.sv
`timescale 1ns/1ps

module reg_decode
  import sm_pkg::*;
(
  input  logic                 clk_ext,
  input  logic                 rst_ext,
  input  logic                 cpu_cs,
  input  logic                 cpu_rnw,
  input  logic [addr_w-1:0]    cpu_addr,
  input  logic [data_w-1:0]    cpu_wdata,
  input  logic [leds_w-1:0]    leds,
  input  logic [fft_w-1:0]     fft_size,
  input  logic [mode_w-1:0]    mode,
  input  logic [ram_aw-1:0]    res_addr,
  input  logic                 busy,
  input  logic [seq_w-1:0]     pkt_seq,
  input  logic [timer_w-1:0]   timer0,
  input  logic [timer_w-1:0]   timer1,
  input  logic [timer_w-1:0]   timer2,
  output logic [data_w-1:0]    cpu_rdata,
  output logic                 we_leds,
  output logic                 we_fft_size,
  output logic                 we_mode,
  output logic                 we_res_addr,
  output logic                 we_res_data,
  output logic                 we_send,
  output logic                 we_tmr_start,
  output logic                 we_tmr_stop
);

  logic [reg_idx_w-1:0] word_idx;
  logic                 wr;       // bus write this cycle
  logic                 we_status;
  logic                 bad_wr;   // write to ro or unmapped word
  logic                 wr_err;   // sticky, status bit 1

  assign word_idx = cpu_addr[addr_w-1:2]; // byte lanes ignored
  assign wr       = cpu_cs & ~cpu_rnw;

  // ==================================================
  // write strobes, same cycle as the bus write
  // ==================================================
  assign we_leds      = wr & (word_idx == reg_leds);
  assign we_fft_size  = wr & (word_idx == reg_fft_size);
  assign we_mode      = wr & (word_idx == reg_mode);
  assign we_res_addr  = wr & (word_idx == reg_res_addr);
  assign we_res_data  = wr & (word_idx == reg_res_data);
  assign we_send      = wr & (word_idx == reg_send);
  assign we_tmr_start = wr & (word_idx == reg_tmr_start);
  assign we_tmr_stop  = wr & (word_idx == reg_tmr_stop);
  assign we_status    = wr & (word_idx == reg_status);

  assign bad_wr = wr & ~(we_leds | we_fft_size | we_mode | we_res_addr | we_res_data |
                         we_send | we_tmr_start | we_tmr_stop | we_status);

  // write error flag, cleared by writing 1 to status bit 1
  always_ff @(posedge clk_ext) begin
    if (rst_ext) begin
      wr_err <= 1'b0;
    end else if (bad_wr) begin
      wr_err <= 1'b1;
    end else if (we_status && cpu_wdata[1]) begin
      wr_err <= 1'b0; // w1c
    end
  end

  // ==================================================
  // read mux, combinational
  // ==================================================
  always_comb begin
    case (word_idx)
      reg_id:       cpu_rdata = firmware_id;
      reg_version:  cpu_rdata = {fw_major, fw_minor};
      reg_status:   cpu_rdata = {16'b0, pkt_seq, 6'b0, wr_err, busy};
      reg_leds:     cpu_rdata = data_w'(leds);
      reg_fft_size: cpu_rdata = data_w'(fft_size);
      reg_mode:     cpu_rdata = data_w'(mode);
      reg_res_addr: cpu_rdata = data_w'(res_addr); // current write pointer
      reg_timer0:   cpu_rdata = timer0;
      reg_timer1:   cpu_rdata = timer1;
      reg_timer2:   cpu_rdata = timer2;
      default:      cpu_rdata = bad_read;          // incl. write-only words
    endcase
  end

endmodule

// File: ctrl_regs.sv
`timescale 1ns/1ps

module ctrl_regs
  import sm_pkg::*;
(
  input  logic                 clk_ext,
  input  logic                 rst_ext,
  input  logic [data_w-1:0]    cpu_wdata,
  input  logic                 we_leds,
  input  logic                 we_fft_size,
  input  logic                 we_mode,
  input  logic                 we_res_addr,
  input  logic                 we_res_data,
  input  logic                 we_send,
  input  logic                 we_tmr_start,
  input  logic                 we_tmr_stop,
  output logic [leds_w-1:0]    leds,
  output logic [fft_w-1:0]     fft_size,
  output logic [mode_w-1:0]    mode,
  output logic [ram_aw-1:0]    res_addr,
  output logic                 ram_we,
  output logic [ram_aw-1:0]    ram_waddr,
  output logic [data_w-1:0]    ram_wdata,
  output logic                 send_stb,
  output logic                 tmr_start_stb,
  output logic                 tmr_stop_stb
);

  // ==================================================
  // software registers
  // ==================================================
  always_ff @(posedge clk_ext) begin
    if (rst_ext) begin
      leds     <= leds_rst;  // 1010 pattern
      fft_size <= fft_rst;   // default 1024 point
      mode     <= '0;
    end else begin
      if (we_leds)     leds     <= cpu_wdata[leds_w-1:0];
      if (we_fft_size) fft_size <= cpu_wdata[fft_w-1:0]; // clamped in framer
      if (we_mode)     mode     <= cpu_wdata[mode_w-1:0];
    end
  end

  // result write pointer
  // load on res_addr, step after every res_data store
  always_ff @(posedge clk_ext) begin
    if (rst_ext) begin
      res_addr <= '0;
    end else if (we_res_addr) begin
      res_addr <= cpu_wdata[ram_aw-1:0];
    end else if (we_res_data) begin
      res_addr <= res_addr + 1'b1; // wraps at ram_depth
    end
  end

  // ram port, stored at the same edge as the bus write
  assign ram_we    = we_res_data;
  assign ram_waddr = res_addr;   // pre-increment value
  assign ram_wdata = cpu_wdata;

  // ==================================================
  // command strobes, one cycle after the write
  // ==================================================
  always_ff @(posedge clk_ext) begin
    if (rst_ext) begin
      send_stb      <= 1'b0;
      tmr_start_stb <= 1'b0;
      tmr_stop_stb  <= 1'b0;
    end else begin
      send_stb      <= we_send;      // data value ignored
      tmr_start_stb <= we_tmr_start;
      tmr_stop_stb  <= we_tmr_stop;
    end
  end

endmodule

// File: latency_timers.sv
`timescale 1ns/1ps

module latency_timers
  import sm_pkg::*;
(
  input  logic                 clk_ext,
  input  logic                 rst_ext,
  input  logic                 send_stb,
  input  logic                 hdr_done_stb,
  input  logic                 pkt_done_stb,
  input  logic                 tmr_start_stb,
  input  logic                 tmr_stop_stb,
  output logic [timer_w-1:0]   timer0,
  output logic [timer_w-1:0]   timer1,
  output logic [timer_w-1:0]   timer2
);

  logic [2:0]         start_v;  // per timer start
  logic [2:0]         stop_v;   // per timer stop
  logic [2:0]         running;
  logic [timer_w-1:0] cnt [3];

  // 0: send -> header acked, 1: send -> last word acked, 2: cpu controlled
  assign start_v = {tmr_start_stb, send_stb, send_stb};
  assign stop_v  = {tmr_stop_stb, pkt_done_stb, hdr_done_stb};

  // start clears and arms, stop freezes until next start
  // the stop edge still counts, so timer2 = cycles between the two writes
  always_ff @(posedge clk_ext) begin
    if (rst_ext) begin
      running <= '0;
      for (int i = 0; i < 3; i++) begin
        cnt[i] <= '0;
      end
    end else begin
      for (int i = 0; i < 3; i++) begin
        if (start_v[i]) begin
          cnt[i]     <= '0;
          running[i] <= 1'b1;
        end else begin
          if (running[i]) cnt[i] <= cnt[i] + 1'b1;
          if (stop_v[i])  running[i] <= 1'b0; // stop with no start is a no-op
        end
      end
    end
  end

  assign timer0 = cnt[0];
  assign timer1 = cnt[1];
  assign timer2 = cnt[2];

endmodule

// File: result_ram.sv
`timescale 1ns/1ps

module result_ram
  import sm_pkg::*;
(
  input  logic                 clk_ext,
  input  logic                 we,
  input  logic [ram_aw-1:0]    waddr,
  input  logic [data_w-1:0]    wdata,
  input  logic [ram_aw-1:0]    raddr,
  output logic [data_w-1:0]    rdata
);

  // ==================================================
  // result words, filled by cpu, read by framer
  // ==================================================
  logic [data_w-1:0] mem [ram_depth];

  // write port
  always_ff @(posedge clk_ext) begin
    if (we) begin
      mem[waddr] <= wdata;
    end
  end

  // registered read, one cycle latency
  // old data on a same-address collision
  always_ff @(posedge clk_ext) begin
    rdata <= mem[raddr];
  end

endmodule

// File: packet_framer.sv
`timescale 1ns/1ps

module packet_framer
  import sm_pkg::*;
(
  input  logic                 clk_ext,
  input  logic                 rst_ext,
  input  logic                 send_stb,
  input  logic [fft_w-1:0]     fft_size,
  input  logic [mode_w-1:0]    mode,
  input  logic                 pkt_ack,
  input  logic [data_w-1:0]    rd_data,
  output logic [ram_aw-1:0]    rd_addr,
  output logic                 pkt_req,
  output logic [data_w-1:0]    pkt_data,
  output logic                 busy,
  output logic [seq_w-1:0]     pkt_seq,
  output logic                 hdr_done_stb,
  output logic                 pkt_done_stb
);

  logic [2:0]       state;
  logic [cnt_w-1:0] words_left;  // data words not yet acked
  logic [fft_w-1:0] fft_clamp;
  logic [cnt_w-1:0] word_count;  // 2^(clamp-5)
  pkt_word_u        hdr_word;
  logic             present_hdr; // load header, raise req
  logic             present_dat; // load next ram word, raise req

  // ==================================================
  // word count and header
  // ==================================================
  always_comb begin
    fft_clamp = fft_size;
    if (fft_size < fft_w'(fft_log_min)) begin
      fft_clamp = fft_w'(fft_log_min);   // floor, one word
    end else if (fft_size > fft_w'(fft_log_max)) begin
      fft_clamp = fft_w'(fft_log_max);   // ceiling, full ram
    end
    word_count = cnt_w'(1) << (fft_clamp - fft_w'(fft_log_min));
  end

  always_comb begin
    hdr_word.hdr.seq   = pkt_seq;   // already bumped at send
    hdr_word.hdr.total = 8'd1;      // single packet only
    hdr_word.hdr.spare = 8'd0;
    hdr_word.hdr.mode  = mode[7:0];
  end

  // a new word goes out only once ack is back low
  assign present_hdr = (state == st_fetch) && !pkt_ack;
  assign present_dat = ((state == st_header) || (state == st_data)) && !pkt_req && !pkt_ack;

  // ==================================================
  // fsm, idle -> fetch -> header -> data -> done
  // ==================================================
  always_ff @(posedge clk_ext) begin
    if (rst_ext) begin
      state        <= st_idle;
      busy         <= 1'b0;
      pkt_req      <= 1'b0;
      pkt_seq      <= '0;
      rd_addr      <= '0;
      words_left   <= '0;
      hdr_done_stb <= 1'b0;
      pkt_done_stb <= 1'b0;
    end else begin
      hdr_done_stb <= 1'b0;
      pkt_done_stb <= 1'b0;
      if (present_hdr || present_dat) pkt_req <= 1'b1;
      if (present_dat) rd_addr <= rd_addr + 1'b1; // prefetch next word
      case (state)
        st_idle: begin
          if (send_stb) begin            // ignored unless idle
            state      <= st_fetch;
            busy       <= 1'b1;
            pkt_seq    <= pkt_seq + 1'b1;
            words_left <= word_count;
            rd_addr    <= '0;            // word 0 ready by first data phase
          end
        end
        st_fetch: begin
          if (present_hdr) state <= st_header; // req 2 cycles after send_stb
        end
        st_header: begin
          if (pkt_req && pkt_ack) begin
            pkt_req      <= 1'b0;
            hdr_done_stb <= 1'b1;        // stops timer0
          end
          if (present_dat) state <= st_data;
        end
        st_data: begin
          if (pkt_req && pkt_ack) begin
            pkt_req    <= 1'b0;
            words_left <= words_left - 1'b1;
            if (words_left == cnt_w'(1)) begin
              pkt_done_stb <= 1'b1;      // last word acked
              state        <= st_done;
            end
          end
        end
        st_done: begin
          busy  <= 1'b0;                 // ack drop checked by fetch
          state <= st_idle;
        end
        default: state <= st_idle;
      endcase
    end
  end

  // payload, held while req is high
  always_ff @(posedge clk_ext) begin
    if (present_hdr) begin
      pkt_data <= hdr_word.raw;
    end else if (present_dat) begin
      pkt_data <= rd_data;
    end
  end

endmodule

// File: spectrum_monitor_top.sv
`timescale 1ns/1ps

module spectrum_monitor_top
  import sm_pkg::*;
(
  input  logic                 clk_ext,
  input  logic                 rst_ext,
  input  logic                 cpu_cs,
  input  logic                 cpu_rnw,
  input  logic [addr_w-1:0]    cpu_addr,
  input  logic [data_w-1:0]    cpu_wdata,
  input  logic                 pkt_ack,
  output logic [data_w-1:0]    cpu_rdata,
  output logic                 pkt_req,
  output logic [data_w-1:0]    pkt_data,
  output logic [leds_w-1:0]    leds
);

  // ==================================================
  // interconnect
  // ==================================================
  logic we_leds, we_fft_size, we_mode, we_res_addr;
  logic we_res_data, we_send, we_tmr_start, we_tmr_stop;
  logic [fft_w-1:0]   fft_size;
  logic [mode_w-1:0]  mode;
  logic [ram_aw-1:0]  res_addr;
  logic               busy;
  logic [seq_w-1:0]   pkt_seq;
  logic [timer_w-1:0] timer0, timer1, timer2;
  logic               ram_we;
  logic [ram_aw-1:0]  ram_waddr, rd_addr;
  logic [data_w-1:0]  ram_wdata, rd_data;
  logic send_stb, tmr_start_stb, tmr_stop_stb;
  logic hdr_done_stb, pkt_done_stb;

  // cpu address decode
  reg_decode reg_decode_inst (
    .clk_ext, .rst_ext, .cpu_cs, .cpu_rnw, .cpu_addr, .cpu_wdata,
    .leds, .fft_size, .mode, .res_addr, .busy, .pkt_seq,
    .timer0, .timer1, .timer2, .cpu_rdata,
    .we_leds, .we_fft_size, .we_mode, .we_res_addr,
    .we_res_data, .we_send, .we_tmr_start, .we_tmr_stop
  );

  // sw registers, write pointer, command strobes
  ctrl_regs ctrl_regs_inst (
    .clk_ext, .rst_ext, .cpu_wdata,
    .we_leds, .we_fft_size, .we_mode, .we_res_addr,
    .we_res_data, .we_send, .we_tmr_start, .we_tmr_stop,
    .leds, .fft_size, .mode, .res_addr,
    .ram_we, .ram_waddr, .ram_wdata,
    .send_stb, .tmr_start_stb, .tmr_stop_stb
  );

  latency_timers latency_timers_inst (
    .clk_ext, .rst_ext, .send_stb, .hdr_done_stb, .pkt_done_stb,
    .tmr_start_stb, .tmr_stop_stb, .timer0, .timer1, .timer2
  );

  result_ram result_ram_inst (
    .clk_ext, .we(ram_we), .waddr(ram_waddr), .wdata(ram_wdata),
    .raddr(rd_addr), .rdata(rd_data)
  );

  // header + result words out over req/ack
  packet_framer packet_framer_inst (
    .clk_ext, .rst_ext, .send_stb, .fft_size, .mode, .pkt_ack, .rd_data,
    .rd_addr, .pkt_req, .pkt_data, .busy, .pkt_seq, .hdr_done_stb, .pkt_done_stb
  );

endmodule

// File: tb_tasks.svh
// ==================================================
// random numbers
// ==================================================
logic [31:0]       stim_rng = 32'hb34f_1faa; // main stimulus stream
logic [data_w-1:0] model_mem [ram_depth];    // mirror of result ram
logic [seq_w-1:0]  model_seq = '0;           // last sequence number sent

function automatic logic [31:0] xorshift(input logic [31:0] s);
  logic [31:0] x;
  x = s;
  x = x ^ (x << 13);
  x = x ^ (x >> 17);
  x = x ^ (x << 5);
  return x;
endfunction

function automatic logic [31:0] rand32();
  stim_rng = xorshift(stim_rng);
  return stim_rng;
endfunction

// ==================================================
// cpu bus, entered and left on a falling edge
// ==================================================
task automatic write_reg(input logic [reg_idx_w-1:0] idx, input logic [data_w-1:0] val);
  logic [31:0] r;
  r = rand32();
  cpu_cs    = 1'b1;
  cpu_rnw   = 1'b0;
  cpu_addr  = {idx, r[1:0]}; // byte lane bits are don't care
  cpu_wdata = val;
  @(negedge clk_ext);        // write lands on the rising edge in between
  cpu_cs    = 1'b0;
  cpu_rnw   = 1'b1;
endtask

task automatic read_reg(input logic [reg_idx_w-1:0] idx, output logic [data_w-1:0] val);
  logic [31:0] r;
  r = rand32();
  cpu_cs   = 1'b1;
  cpu_rnw  = 1'b1;
  cpu_addr = {idx, r[1:0]};
  #1 val = cpu_rdata;        // combinational, settled well before the rising edge
  @(negedge clk_ext);
  cpu_cs   = 1'b0;
endtask

task automatic check_reg(input logic [reg_idx_w-1:0] idx, input logic [data_w-1:0] exp,
                         input string name);
  logic [data_w-1:0] got;
  read_reg(idx, got);
  assert (got === exp) else mismatch(name, got, exp);
endtask

// ==================================================
// reference packet model
// ==================================================
function automatic int ref_count(input int fft);
  int n;
  n = (fft < fft_log_min) ? fft_log_min : (fft > fft_log_max) ? fft_log_max : fft;
  return 1 << (n - fft_log_min); // one word per 32 fft bins
endfunction

// word 0 is the header, then ram words in order
function automatic logic [data_w-1:0] ref_word(input int idx, input logic [7:0] mode_v,
                                               input logic [seq_w-1:0] seq);
  pkt_word_u w;
  if (idx > 0) return model_mem[idx-1];
  w.hdr.seq   = seq;
  w.hdr.total = 8'd1;
  w.hdr.spare = 8'd0;
  w.hdr.mode  = mode_v;
  return w.raw;
endfunction

task automatic expect_packet(input int fft, input logic [7:0] mode_v);
  model_seq = model_seq + 1'b1; // framer bumps seq before the header
  for (int i = 0; i <= ref_count(fft); i++) begin
    exp_q.push_back(ref_word(i, mode_v, model_seq));
  end
endtask

// File: tb_spectrum_monitor.sv
`timescale 1ns/1ps

module tb_spectrum_monitor
  import sm_pkg::*;
();

  logic              clk_ext;
  logic              rst_ext;
  logic              cpu_cs;
  logic              cpu_rnw;
  logic [addr_w-1:0] cpu_addr;
  logic [data_w-1:0] cpu_wdata;
  logic [data_w-1:0] cpu_rdata;
  logic              pkt_req;
  logic              pkt_ack;
  logic [data_w-1:0] pkt_data;
  logic [leds_w-1:0] leds;

  logic [data_w-1:0] exp_q [$];                      // words still owed by the framer
  logic [31:0]       sink_rng = ~32'hb34f_1faa;      // separate stream for ack delays
  int                fft_plan [5] = '{3, 5, 7, 10, 10}; // last one also tries a resend

  `include "tb_tasks.svh"

  spectrum_monitor_top spectrum_monitor_top_inst (
    .clk_ext, .rst_ext, .cpu_cs, .cpu_rnw, .cpu_addr, .cpu_wdata,
    .pkt_ack, .cpu_rdata, .pkt_req, .pkt_data, .leds
  );

  initial begin : clock_gen
    clk_ext = 1'b0;
    forever #2 clk_ext = ~clk_ext; // 4 ns period
  end

  task automatic fail_now(input string why);
    $display("%s", why);
    $display("=== FAIL ===");
    $fatal(1, "stopped at first error");
  endtask

  task automatic mismatch(input string name, input logic [data_w-1:0] got,
                          input logic [data_w-1:0] exp);
    fail_now($sformatf("Mismatch at %0d ns: %s = %h, expected %h", $time, name, got, exp));
  endtask

  // ==================================================
  // sink side of the four-phase handshake
  // ==================================================
  initial begin : sink_responder
    int unsigned delay;
    forever begin
      @(negedge clk_ext);
      if (pkt_req !== pkt_ack && pkt_req !== 1'bx) begin
        sink_rng = xorshift(sink_rng);
        delay    = sink_rng % 4;               // 0..3 cycles of back-pressure
        repeat (delay) @(negedge clk_ext);
        pkt_ack = pkt_req;                     // raise after req, drop after req falls
      end
    end
  end

  // each word is taken when ack rises
  initial begin : compare_words
    logic [data_w-1:0] exp_word;
    forever begin
      @(posedge pkt_ack);
      assert (exp_q.size() > 0) else fail_now("packet word arrived with no packet expected");
      exp_word = exp_q.pop_front();
      assert (pkt_data === exp_word) else mismatch("pkt_data", pkt_data, exp_word);
    end
  end

  // data must not move while req is up
  initial begin : hold_check
    logic              req_d;
    logic [data_w-1:0] data_d;
    req_d  = 1'b0;
    data_d = '0;
    forever begin
      @(negedge clk_ext);
      if (req_d && pkt_req) begin
        assert (pkt_data === data_d) else mismatch("pkt_data (held)", pkt_data, data_d);
      end
      req_d  = pkt_req;
      data_d = pkt_data;
    end
  end

  initial begin : watchdog
    int words;
    words = 0;
    foreach (fft_plan[p]) words += ref_count(fft_plan[p]) + 1; // header + data
    repeat (200 * words + 2000) @(posedge clk_ext);
    fail_now($sformatf("timeout, test still running after %0d cycles", 200 * words + 2000));
  end

  // ==================================================
  // packet helpers
  // ==================================================
  task automatic wait_idle();
    logic [data_w-1:0] st;
    st = 32'h1;
    while (st[0] || exp_q.size() != 0) read_reg(reg_status, st); // watchdog bounds this
  endtask

  task automatic check_pkt_timers();
    logic [data_w-1:0] t0, t1;
    read_reg(reg_timer0, t0);
    read_reg(reg_timer1, t1);
    assert (t0 >= 2 && t1 > t0) else
      fail_now($sformatf("packet timers out of order, timer0 %0d timer1 %0d", t0, t1));
    repeat (rand32() % 8) @(negedge clk_ext);
    check_reg(reg_timer0, t0, "timer0");     // frozen until next send
    check_reg(reg_timer1, t1, "timer1");
  endtask

  task automatic send_packet(input int fft, input bit resend);
    logic [data_w-1:0] m;
    logic [data_w-1:0] st;
    m = rand32();
    write_reg(reg_mode, m);
    write_reg(reg_fft_size, fft);
    expect_packet(fft, m[7:0]);
    write_reg(reg_send, 32'd1);
    // header req two cycles behind the send strobe
    for (int c = 0; c < 2; c++) begin
      assert (pkt_req === 1'b0) else mismatch("pkt_req", data_w'(pkt_req), 32'd0);
      @(negedge clk_ext);
    end
    assert (pkt_req === 1'b1) else mismatch("pkt_req", data_w'(pkt_req), 32'd1);
    if (resend) begin
      st = '0;
      for (int k = 0; k < 8 && !st[0]; k++) read_reg(reg_status, st);
      assert (st[0]) else fail_now("status busy never set after a send");
      write_reg(reg_send, 32'd1);            // must be dropped, framer busy
    end
    wait_idle();
    check_reg(reg_status, {16'b0, model_seq, 8'b0}, "cpu_rdata(status)"); // no skipped seq
    check_pkt_timers();
  endtask

  // ==================================================
  // test sequence
  // ==================================================
  initial begin : main_test
    logic [data_w-1:0] v;
    int                n;
    rst_ext   = 1'b1;
    cpu_cs    = 1'b0;
    cpu_rnw   = 1'b1;
    cpu_addr  = '0;
    cpu_wdata = '0;
    pkt_ack   = 1'b0;
    repeat (2) @(negedge clk_ext);
    rst_ext = 1'b0;

    // reset values
    check_reg(reg_id, firmware_id, "cpu_rdata(id)");
    check_reg(reg_version, {fw_major, fw_minor}, "cpu_rdata(version)");
    check_reg(reg_leds, 32'h0000_000a, "cpu_rdata(leds)");
    check_reg(reg_fft_size, 32'd10, "cpu_rdata(fft_size)");
    check_reg(reg_mode, 32'd0, "cpu_rdata(mode)");
    check_reg(reg_status, 32'd0, "cpu_rdata(status)");
    check_reg(reg_timer0, 32'd0, "cpu_rdata(timer0)");
    check_reg(reg_timer1, 32'd0, "cpu_rdata(timer1)");
    check_reg(reg_timer2, 32'd0, "cpu_rdata(timer2)");
    check_reg(6'd14, bad_read, "cpu_rdata(unmapped)");
    check_reg(reg_send, bad_read, "cpu_rdata(send)"); // write only
    assert (leds === 4'b1010) else mismatch("leds", data_w'(leds), 32'ha);
    assert (pkt_req === 1'b0) else mismatch("pkt_req", data_w'(pkt_req), 32'd0);

    // random register writes, masked readback
    repeat (4) begin
      v = rand32();
      write_reg(reg_leds, v);
      check_reg(reg_leds, {28'b0, v[3:0]}, "cpu_rdata(leds)");
      assert (leds === v[3:0]) else mismatch("leds", data_w'(leds), {28'b0, v[3:0]});
      v = rand32();
      write_reg(reg_mode, v);
      check_reg(reg_mode, {24'b0, v[7:0]}, "cpu_rdata(mode)");
      v = rand32();
      write_reg(reg_fft_size, v);
      check_reg(reg_fft_size, {27'b0, v[4:0]}, "cpu_rdata(fft_size)");
    end

    // write to a read-only word sets status bit 1, w1c
    write_reg(reg_id, rand32());
    check_reg(reg_status, 32'h0000_0002, "cpu_rdata(status)");
    check_reg(reg_id, firmware_id, "cpu_rdata(id)");   // id unchanged
    write_reg(reg_status, 32'h0000_0002);
    check_reg(reg_status, 32'd0, "cpu_rdata(status)");

    // fill result ram through the pointer pair
    write_reg(reg_res_addr, 32'd0);
    for (int i = 0; i < ram_depth; i++) begin
      model_mem[i] = rand32();
      write_reg(reg_res_data, model_mem[i]);
    end
    check_reg(reg_res_addr, 32'd0, "cpu_rdata(res_addr)"); // wrapped after 32 stores

    foreach (fft_plan[p]) send_packet(fft_plan[p], p == 4);

    // user timer, start and stop n cycles apart
    repeat (3) begin
      n = int'(rand32() % 40) + 1;
      write_reg(reg_tmr_start, 32'd0);
      repeat (n - 1) @(negedge clk_ext);
      write_reg(reg_tmr_stop, 32'd0);
      repeat (2) @(negedge clk_ext); // stop strobe lands a cycle later
      check_reg(reg_timer2, n, "cpu_rdata(timer2)");
    end

    $display("=== PASS ===");
    $finish;
  end

endmodule

// File: project.f
+incdir+.
sm_pkg.sv
reg_decode.sv
ctrl_regs.sv
latency_timers.sv
result_ram.sv
packet_framer.sv
spectrum_monitor_top.sv
tb_spectrum_monitor.sv

// File: Makefile
# Verilator build and run for the spectrum monitor testbench

VERILATOR ?= verilator
TOP       ?= tb_spectrum_monitor
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SIM_BIN := $(OBJ_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST)) tb_tasks.svh

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "=== FAIL ===" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "=== PASS ===" $(LOG) || (echo "simulation ended without a result"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
